// ==== Bender.yml ====
package:
  name: riscv

export_include_dirs:
  - .

sources:
  - riscv_isa_pkg.sv
  - riscv_pipe_pkg.sv
  - main_control.sv
  - register_file.sv
  - alu.sv
  - hazard_detection_unit.sv
  - forwarding_unit.sv
  - riscv.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_riscv.sv

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_config.svh"

module alu (
    input  riscv_isa_pkg::alu_op_e     op,
    input  logic [`RISCV_XLEN-1:0]     a,
    input  logic [`RISCV_XLEN-1:0]     b,
    output logic [`RISCV_XLEN-1:0]     result
);
    import riscv_isa_pkg::*;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            // signed compare
            SLT:     result = {{(`RISCV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
riscv_isa_pkg.sv
riscv_pipe_pkg.sv
main_control.sv
register_file.sv
alu.sv
hazard_detection_unit.sv
forwarding_unit.sv
riscv.sv
tb_clock_gen.sv
tb_riscv.sv

// ==== forwarding_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_config.svh"

module forwarding_unit (
    input  logic [`RISCV_REG_AW-1:0]   ex_rs1,
    input  logic [`RISCV_REG_AW-1:0]   ex_rs2,
    input  logic [`RISCV_REG_AW-1:0]   id_rs1,
    input  logic [`RISCV_REG_AW-1:0]   id_rs2,
    input  riscv_pipe_pkg::ex_mem_t    ex_mem,
    input  riscv_pipe_pkg::mem_wb_t    mem_wb,
    output riscv_pipe_pkg::fwd_sel_e   fwd_a,
    output riscv_pipe_pkg::fwd_sel_e   fwd_b,
    output riscv_pipe_pkg::fwd_sel_e   fwd_br_a,
    output riscv_pipe_pkg::fwd_sel_e   fwd_br_b
);
    import riscv_pipe_pkg::*;

    logic ex_mem_ok;
    logic mem_wb_ok;

    // loads in ex_mem have no data yet
    assign ex_mem_ok = ex_mem.valid && ex_mem.ctrl.regwrite && !ex_mem.ctrl.memread &&
                       ex_mem.rd != '0;
    assign mem_wb_ok = mem_wb.valid && mem_wb.regwrite && mem_wb.rd != '0;

    function automatic fwd_sel_e alu_src(input logic [`RISCV_REG_AW-1:0] rs);
        if (ex_mem_ok && ex_mem.rd == rs) return FWD_EXMEM;
        if (mem_wb_ok && mem_wb.rd == rs) return FWD_MEMWB;
        return FWD_REG;
    endfunction

    assign fwd_a = alu_src(ex_rs1);
    assign fwd_b = alu_src(ex_rs2);

    // mem_wb to decode goes through the register file bypass
    assign fwd_br_a = (ex_mem_ok && ex_mem.rd == id_rs1) ? FWD_EXMEM : FWD_REG;
    assign fwd_br_b = (ex_mem_ok && ex_mem.rd == id_rs2) ? FWD_EXMEM : FWD_REG;

endmodule

`default_nettype wire

// ==== hazard_detection_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_config.svh"

module hazard_detection_unit (
    input  logic [`RISCV_REG_AW-1:0]  id_rs1,
    input  logic [`RISCV_REG_AW-1:0]  id_rs2,
    input  logic                      id_is_branch,
    input  logic                      branch_equal,
    input  riscv_pipe_pkg::id_ex_t    id_ex,
    input  riscv_pipe_pkg::ex_mem_t   ex_mem,
    output logic                      stall,
    output logic                      flush
);

    logic load_use;
    logic branch_dep_ex;
    logic branch_dep_mem;

    function automatic logic reads(input logic [`RISCV_REG_AW-1:0] rd,
                                   input logic [`RISCV_REG_AW-1:0] rs1,
                                   input logic [`RISCV_REG_AW-1:0] rs2);
        return rd != '0 && (rd == rs1 || rd == rs2);
    endfunction

    assign load_use = id_ex.valid && id_ex.ctrl.memread && reads(id_ex.rd, id_rs1, id_rs2);

    // compare in decode needs its operands one stage earlier than the alu
    assign branch_dep_ex = id_is_branch && id_ex.valid && id_ex.ctrl.regwrite &&
                           reads(id_ex.rd, id_rs1, id_rs2);
    assign branch_dep_mem = id_is_branch && ex_mem.valid && ex_mem.ctrl.memread &&
                            reads(ex_mem.rd, id_rs1, id_rs2);

    assign stall = load_use || branch_dep_ex || branch_dep_mem;
    assign flush = id_is_branch && branch_equal && !stall;

endmodule

`default_nettype wire

// ==== main_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_control (
    input  logic [31:0]           instr,
    output riscv_isa_pkg::ctrl_t  ctrl
);
    import riscv_isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    // funct3 to alu op; sub only for register-register
    function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic sub_sel);
        case (f3)
            3'b000:  return sub_sel ? SUB : ADD;
            3'b010:  return SLT;
            3'b110:  return OR;
            3'b111:  return AND;
            default: return ADD;
        endcase
    endfunction

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP: begin
                ctrl.regwrite = 1'b1;
                ctrl.alu_op   = decode_alu(funct3, funct7_5);
            end
            OP_IMM: begin
                ctrl.regwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                ctrl.alu_op   = decode_alu(funct3, 1'b0);
            end
            LOAD: begin
                ctrl.regwrite = 1'b1;
                ctrl.memread  = 1'b1;
                ctrl.memtoreg = 1'b1;
                ctrl.alusrc   = 1'b1;
                ctrl.alu_op   = ADD;
            end
            STORE: begin
                ctrl.memwrite = 1'b1;
                ctrl.alusrc   = 1'b1;
                ctrl.alu_op   = ADD;
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = SUB;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_config.svh"

module register_file (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`RISCV_REG_AW-1:0]  rs1,
    input  logic [`RISCV_REG_AW-1:0]  rs2,
    output logic [`RISCV_XLEN-1:0]    rs1_data,
    output logic [`RISCV_XLEN-1:0]    rs2_data,
    input  logic                      we,
    input  logic [`RISCV_REG_AW-1:0]  rd,
    input  logic [`RISCV_XLEN-1:0]    wd
);

    logic [`RISCV_XLEN-1:0] regs [`RISCV_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RISCV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 reads zero, a same-cycle write is bypassed
    assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

`default_nettype wire

// ==== riscv.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_config.svh"

module riscv (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       imem_we,
    input  logic [`RISCV_IMEM_AW-1:0]  imem_addr,
    input  logic [`RISCV_XLEN-1:0]     imem_wdata,
    output logic                       wb_valid,
    output logic [`RISCV_REG_AW-1:0]   wb_rd,
    output logic [`RISCV_XLEN-1:0]     wb_data
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    logic [`RISCV_XLEN-1:0] imem [`RISCV_IMEM_WORDS];
    logic [`RISCV_XLEN-1:0] dmem [`RISCV_DMEM_WORDS];

    logic [`RISCV_XLEN-1:0] pc;
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    ctrl_t                    id_ctrl;
    logic [31:0]              id_instr;
    logic [`RISCV_REG_AW-1:0] id_rs1;
    logic [`RISCV_REG_AW-1:0] id_rs2;
    logic [`RISCV_XLEN-1:0]   id_imm;
    logic [`RISCV_XLEN-1:0]   rf_rs1_data;
    logic [`RISCV_XLEN-1:0]   rf_rs2_data;
    logic [`RISCV_XLEN-1:0]   br_a;
    logic [`RISCV_XLEN-1:0]   br_b;
    logic [`RISCV_XLEN-1:0]   br_target;
    logic                     id_is_branch;
    logic                     branch_equal;
    logic                     stall;
    logic                     flush;

    fwd_sel_e                 fwd_a;
    fwd_sel_e                 fwd_b;
    fwd_sel_e                 fwd_br_a;
    fwd_sel_e                 fwd_br_b;
    logic [`RISCV_XLEN-1:0]   ex_a;
    logic [`RISCV_XLEN-1:0]   ex_rs2_val;
    logic [`RISCV_XLEN-1:0]   ex_b;
    logic [`RISCV_XLEN-1:0]   ex_result;

    logic [`RISCV_DMEM_AW-1:0] dmem_addr;
    logic [`RISCV_XLEN-1:0]    mem_rdata;

    function automatic logic [`RISCV_XLEN-1:0] fwd_value(
        input fwd_sel_e               sel,
        input logic [`RISCV_XLEN-1:0] reg_value,
        input logic [`RISCV_XLEN-1:0] exmem_value,
        input logic [`RISCV_XLEN-1:0] memwb_value
    );
        case (sel)
            FWD_EXMEM: return exmem_value;
            FWD_MEMWB: return memwb_value;
            default:   return reg_value;
        endcase
    endfunction

    // fetch
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= '0;
            if_id <= '0;
        end else if (flush) begin
            pc    <= br_target;
            if_id <= '0;
        end else if (!stall) begin
            pc          <= pc + `RISCV_XLEN'd4;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem[pc[`RISCV_IMEM_AW+1:2]];
        end
    end

    // decode
    assign id_instr = if_id.instr;

    main_control u_main_control (
        .instr (id_instr),
        .ctrl  (id_ctrl)
    );

    // i-type has no rs2 so it stays out of hazard checks
    assign id_rs1 = id_instr[19:15];
    assign id_rs2 = (id_ctrl.alusrc && !id_ctrl.memwrite) ? '0 : id_instr[24:20];

    always_comb begin
        case (opcode_e'(id_instr[6:0]))
            STORE:   id_imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
            BRANCH:  id_imm = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                               id_instr[30:25], id_instr[11:8], 1'b0};
            default: id_imm = {{20{id_instr[31]}}, id_instr[31:20]};
        endcase
    end

    register_file u_register_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .we       (wb_valid),
        .rd       (mem_wb.rd),
        .wd       (wb_data)
    );

    // branch resolves here and fetch assumes not taken
    assign br_a         = fwd_value(fwd_br_a, rf_rs1_data, ex_mem.alu_result, wb_data);
    assign br_b         = fwd_value(fwd_br_b, rf_rs2_data, ex_mem.alu_result, wb_data);
    assign branch_equal = br_a == br_b;
    assign br_target    = if_id.pc + id_imm;
    assign id_is_branch = if_id.valid && id_ctrl.branch;

    hazard_detection_unit u_hazard_detection_unit (
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_is_branch (id_is_branch),
        .branch_equal (branch_equal),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .stall        (stall),
        .flush        (flush)
    );

    forwarding_unit u_forwarding_unit (
        .ex_rs1   (id_ex.rs1),
        .ex_rs2   (id_ex.rs2),
        .id_rs1   (id_rs1),
        .id_rs2   (id_rs2),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .fwd_br_a (fwd_br_a),
        .fwd_br_b (fwd_br_b)
    );

    // bubble on stall
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            id_ex.valid <= if_id.valid;
            id_ex.ctrl  <= id_ctrl;
        end
        id_ex.rs1     <= id_rs1;
        id_ex.rs2     <= id_rs2;
        id_ex.rd      <= id_instr[11:7];
        id_ex.rs1_val <= rf_rs1_data;
        id_ex.rs2_val <= rf_rs2_data;
        id_ex.imm     <= id_imm;
    end

    // execute
    assign ex_a       = fwd_value(fwd_a, id_ex.rs1_val, ex_mem.alu_result, wb_data);
    assign ex_rs2_val = fwd_value(fwd_b, id_ex.rs2_val, ex_mem.alu_result, wb_data);
    assign ex_b       = id_ex.ctrl.alusrc ? id_ex.imm : ex_rs2_val;

    alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (ex_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else begin
            ex_mem.valid <= id_ex.valid;
            ex_mem.ctrl  <= id_ex.ctrl;
        end
        ex_mem.rd         <= id_ex.rd;
        ex_mem.alu_result <= ex_result;
        ex_mem.store_data <= ex_rs2_val;
    end

    // memory
    assign dmem_addr = ex_mem.alu_result[`RISCV_DMEM_AW+1:2];
    assign mem_rdata = dmem[dmem_addr];

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.ctrl.memwrite) begin
            dmem[dmem_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid    <= 1'b0;
            mem_wb.regwrite <= 1'b0;
            mem_wb.memtoreg <= 1'b0;
        end else begin
            mem_wb.valid    <= ex_mem.valid;
            mem_wb.regwrite <= ex_mem.ctrl.regwrite;
            mem_wb.memtoreg <= ex_mem.ctrl.memtoreg;
        end
        mem_wb.rd         <= ex_mem.rd;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.load_data  <= mem_rdata;
    end

    // write-back and retire strobe
    assign wb_data  = mem_wb.memtoreg ? mem_wb.load_data : mem_wb.alu_result;
    assign wb_rd    = mem_wb.rd;
    assign wb_valid = mem_wb.valid && mem_wb.regwrite && mem_wb.rd != '0;

    // a load's consumer never sits right behind it in execute
    a_load_use_gap: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.valid && ex_mem.ctrl.memread && ex_mem.rd != '0 && id_ex.valid &&
          (id_ex.rs1 == ex_mem.rd || id_ex.rs2 == ex_mem.rd)));

    // a load feeding a branch is the longest stall
    a_stall_bounded: assert property (@(posedge clk) disable iff (reset)
        stall [*2] |=> !stall);

endmodule

`default_nettype wire

// ==== riscv_config.svh ====
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// datapath and register file
`define RISCV_XLEN 32
`define RISCV_NREGS 32
`define RISCV_REG_AW 5

// word-addressed memories
`define RISCV_IMEM_WORDS 64
`define RISCV_IMEM_AW 6
`define RISCV_DMEM_WORDS 64
`define RISCV_DMEM_AW 6

`endif

// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } alu_op_e;

    // decoded control, carried down the pipe
    typedef struct packed {
        logic    regwrite;
        logic    memread;
        logic    memwrite;
        logic    memtoreg;
        logic    alusrc;
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== riscv_pipe_pkg.sv ====
`default_nettype none

`include "riscv_config.svh"

package riscv_pipe_pkg;

    // operand source for alu and branch compare
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic                    valid;
        logic [`RISCV_XLEN-1:0]  pc;
        logic [`RISCV_XLEN-1:0]  instr;
    } if_id_t;

    typedef struct packed {
        logic                      valid;
        riscv_isa_pkg::ctrl_t      ctrl;
        logic [`RISCV_REG_AW-1:0]  rs1;
        logic [`RISCV_REG_AW-1:0]  rs2;
        logic [`RISCV_REG_AW-1:0]  rd;
        logic [`RISCV_XLEN-1:0]    rs1_val;
        logic [`RISCV_XLEN-1:0]    rs2_val;
        logic [`RISCV_XLEN-1:0]    imm;
    } id_ex_t;

    typedef struct packed {
        logic                      valid;
        riscv_isa_pkg::ctrl_t      ctrl;
        logic [`RISCV_REG_AW-1:0]  rd;
        logic [`RISCV_XLEN-1:0]    alu_result;
        logic [`RISCV_XLEN-1:0]    store_data;
    } ex_mem_t;

    // only the write-back controls survive to this stage
    typedef struct packed {
        logic                      valid;
        logic                      regwrite;
        logic                      memtoreg;
        logic [`RISCV_REG_AW-1:0]  rd;
        logic [`RISCV_XLEN-1:0]    alu_result;
        logic [`RISCV_XLEN-1:0]    load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period_ns = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb_riscv.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_config.svh"

module tb_riscv;

    typedef struct packed {
        logic [4:0]             rd;
        logic [`RISCV_XLEN-1:0] data;
    } retire_t;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] f7_sub    = 7'b0100000;
    // addi x0, x0, 0
    localparam logic [31:0] nop_word  = 32'h00000013;
    // beq x0, x0, 0 spins on itself and retires nothing
    localparam logic [31:0] halt_word = 32'h00000063;
    // seven program loads of 65 cycles and up to 50 run cycles each plus slack
    localparam int timeout_cycles = 2000;

    logic                      clk;
    logic                      reset;
    logic                      imem_we;
    logic [`RISCV_IMEM_AW-1:0] imem_addr;
    logic [`RISCV_XLEN-1:0]    imem_wdata;
    logic                      wb_valid;
    logic [4:0]                wb_rd;
    logic [`RISCV_XLEN-1:0]    wb_data;

    logic [31:0] prog [`RISCV_IMEM_WORDS];
    int          prog_len;
    retire_t     got_q [$];
    retire_t     exp_q [$];
    logic        reset_seen;
    int          cycles = 0;
    logic        failed;

    tb_clock_gen #(.period_ns(10.0)) clock_i (
        .clk (clk)
    );

    riscv dut_i (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    task automatic fail_run(input string why);
        failed = 1'b1;
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, expected));
        end
    endtask

    always @(posedge clk) begin
        reset_seen <= reset;
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            fail_run("timeout: the core did not retire the expected instructions in time");
        end
    end

    // retire monitor samples on the falling edge
    always @(negedge clk) begin
        if (reset_seen === 1'b1) begin
            if (wb_valid !== 1'b0) begin
                fail_run("wb_valid was not low during reset");
            end
        end else if (wb_valid === 1'b1) begin
            if (wb_rd == '0) begin
                fail_run("retire strobe raised for a write to x0");
            end
            got_q.push_back({wb_rd, wb_data});
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [11:0] rand_imm();
        logic [11:0] v;
        v = 12'($urandom_range(4095, 0));
        return v;
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic sub_sel,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub_sel ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    task automatic clear_program();
        foreach (prog[i]) begin
            prog[i] = nop_word;
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // instruction-level reference model
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] mem [`RISCV_DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic        wr;
        int          steps;
        exp_q.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = '0;
        steps = 0;
        ins = prog[0];
        while (ins != halt_word && steps < 256) begin
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            next_pc = pc + 32'd4;
            wr = 1'b1;
            res = '0;
            case (ins[6:0])
                op_reg: res = model_alu(ins[14:12], ins[30], a, b);
                op_imm: res = model_alu(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
                op_load: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    res = mem[addr[`RISCV_DMEM_AW+1:2]];
                end
                op_store: begin
                    wr = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[`RISCV_DMEM_AW+1:2]] = b;
                end
                op_branch: begin
                    wr = 1'b0;
                    if (a == b) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
                exp_q.push_back({ins[11:7], res});
            end
            pc = next_pc;
            ins = prog[pc[`RISCV_IMEM_AW+1:2]];
            steps++;
        end
        if (steps >= 256) begin
            fail_run("reference model never reached the halt instruction");
        end
    endtask

    // whole instruction memory is written while reset is high
    task automatic load_program();
        @(posedge clk);
        #1;
        reset = 1'b1;
        got_q.delete();
        for (int i = 0; i < `RISCV_IMEM_WORDS; i++) begin
            imem_we    = 1'b1;
            imem_addr  = i[`RISCV_IMEM_AW-1:0];
            imem_wdata = prog[i];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        reset   = 1'b0;
    endtask

    task automatic execute_and_check(input string test_name);
        run_model();
        load_program();
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
        end
        // a halted core stays quiet and skipped paths would show up here
        repeat (8) @(posedge clk);
        check_value({test_name, " retire count"}, got_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            check_value($sformatf("%s wb_rd[%0d]", test_name, i), got_q[i].rd, exp_q[i].rd);
            check_value($sformatf("%s wb_data[%0d]", test_name, i),
                        got_q[i].data, exp_q[i].data);
        end
    endtask

    task automatic test_alu_chain();
        clear_program();
        emit(i_type(op_imm, 3'b000, 5'd1, 5'd0, rand_imm()));
        emit(i_type(op_imm, 3'b000, 5'd2, 5'd0, rand_imm()));
        emit(r_type(7'd0, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(r_type(f7_sub, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(r_type(7'd0, 3'b111, 5'd5, 5'd4, 5'd3));
        emit(r_type(7'd0, 3'b110, 5'd6, 5'd5, 5'd2));
        emit(r_type(7'd0, 3'b010, 5'd7, 5'd6, 5'd4));
        emit(r_type(7'd0, 3'b010, 5'd8, 5'd4, 5'd6));
        emit(i_type(op_imm, 3'b000, 5'd9, 5'd7, rand_imm()));
        emit(i_type(op_imm, 3'b010, 5'd10, 5'd1, rand_imm()));
        emit(i_type(op_imm, 3'b110, 5'd11, 5'd2, rand_imm()));
        emit(i_type(op_imm, 3'b111, 5'd12, 5'd3, rand_imm()));
        emit(halt_word);
        execute_and_check("alu chain");
    endtask

    task automatic test_load_store();
        clear_program();
        emit(i_type(op_imm, 3'b000, 5'd1, 5'd0, rand_imm()));
        emit(i_type(op_imm, 3'b000, 5'd2, 5'd0, 12'd16));
        emit(s_type(5'd1, 5'd2, 12'd0));
        emit(i_type(op_load, 3'b010, 5'd3, 5'd2, 12'd0));
        emit(r_type(7'd0, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(i_type(op_imm, 3'b000, 5'd5, 5'd0, rand_imm()));
        emit(s_type(5'd5, 5'd2, 12'd4));
        emit(i_type(op_load, 3'b010, 5'd6, 5'd2, 12'd4));
        emit(i_type(op_load, 3'b010, 5'd7, 5'd2, 12'd0));
        emit(r_type(7'd0, 3'b000, 5'd8, 5'd6, 5'd7));
        emit(s_type(5'd8, 5'd2, 12'd8));
        emit(i_type(op_load, 3'b010, 5'd9, 5'd2, 12'd8));
        emit(halt_word);
        execute_and_check("load store");
    endtask

    task automatic build_branch_program();
        clear_program();
        emit(i_type(op_imm, 3'b000, 5'd1, 5'd0, rand_imm()));
        emit(i_type(op_imm, 3'b000, 5'd2, 5'd1, 12'd0));
        // taken with an operand from the addi just ahead
        emit(b_type(5'd1, 5'd2, 13'd8));
        emit(i_type(op_imm, 3'b000, 5'd3, 5'd0, 12'd1));
        emit(i_type(op_imm, 3'b000, 5'd4, 5'd0, 12'd2));
        emit(i_type(op_imm, 3'b000, 5'd5, 5'd1, 12'd1));
        emit(b_type(5'd5, 5'd1, 13'd8));
        emit(i_type(op_imm, 3'b000, 5'd6, 5'd0, 12'd3));
        emit(s_type(5'd1, 5'd0, 12'd0));
        emit(i_type(op_load, 3'b010, 5'd7, 5'd0, 12'd0));
        // taken with an operand from the load just ahead
        emit(b_type(5'd7, 5'd2, 13'd8));
        emit(i_type(op_imm, 3'b000, 5'd8, 5'd0, 12'd9));
        emit(i_type(op_imm, 3'b000, 5'd9, 5'd0, 12'd4));
        emit(i_type(op_load, 3'b010, 5'd10, 5'd0, 12'd0));
        emit(b_type(5'd10, 5'd4, 13'd8));
        emit(i_type(op_imm, 3'b000, 5'd11, 5'd0, 12'd6));
        emit(halt_word);
    endtask

    task automatic test_branches();
        build_branch_program();
        execute_and_check("branches");
    endtask

    task automatic test_x0_writes();
        clear_program();
        emit(i_type(op_imm, 3'b000, 5'd1, 5'd0, rand_imm()));
        emit(i_type(op_imm, 3'b000, 5'd0, 5'd0, rand_imm()));
        emit(r_type(7'd0, 3'b000, 5'd2, 5'd0, 5'd1));
        emit(r_type(7'd0, 3'b000, 5'd0, 5'd1, 5'd1));
        emit(r_type(f7_sub, 3'b000, 5'd3, 5'd1, 5'd0));
        emit(s_type(5'd1, 5'd0, 12'd12));
        emit(i_type(op_load, 3'b010, 5'd0, 5'd0, 12'd12));
        emit(r_type(7'd0, 3'b000, 5'd4, 5'd0, 5'd0));
        emit(r_type(7'd0, 3'b110, 5'd5, 5'd0, 5'd1));
        emit(halt_word);
        execute_and_check("x0 writes");
    endtask

    task automatic test_repeat_after_reset();
        build_branch_program();
        execute_and_check("first run");
        // the next reset cuts into a program that is still in flight
        load_program();
        repeat (6) @(posedge clk);
        execute_and_check("second run");
    endtask

    initial begin
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        failed     = 1'b0;
        void'($urandom(32'h239ba78d));
        // power-on reset while the monitor watches wb_valid
        repeat (10) @(posedge clk);
        test_alu_chain();
        test_load_store();
        test_branches();
        test_x0_writes();
        test_repeat_after_reset();
        if (failed == 1'b0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run("one or more checks failed");
        end
    end

endmodule

`default_nettype wire
